// ==== common/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path width
`define RV_XLEN 32

// Register index width, 32 architectural registers
`define RV_REG_ADDR_W 5

// Data memory depth in words
`define RV_DMEM_WORDS 256

// Link address offset for JAL and JALR
`define RV_PC_STEP 32'd4

// Stage register reset value
`define RV_RESET_WORD 32'h0000_0000

`endif

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [OPCODE_W-1:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of loads and stores
    // Stores use only B, H and W
    typedef enum logic [FUNCT3_W-1:0] {
        B  = 3'b000,
        H  = 3'b001,
        W  = 3'b010,
        BU = 3'b100,
        HU = 3'b101
    } mem_size_e;

endpackage

// ==== common/rv_pipe_pkg.sv ====
`include "rv_defines.svh"

package rv_pipe_pkg;

    // One data word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register index
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // One strobe per byte lane of a word
    typedef logic [`RV_XLEN/8-1:0] byte_en_t;

    // Source of the write-back value
    typedef enum logic [1:0] {
        NONE = 2'b00,
        LINK = 2'b01,
        ALU  = 2'b10,
        MEM  = 2'b11
    } wb_src_e;

endpackage

// ==== dv/rv_backend_tb.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_backend_tb
    import rv_isa_pkg::*, rv_pipe_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_CYCLES   = 4;
    localparam int MAX_ROWS      = 32;
    localparam int NUM_REGS      = 2 ** `RV_REG_ADDR_W;
    localparam int MARGIN_CYCLES = 40;
    localparam int DRAIN_LIMIT   = 8;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid_i;
    word_t     pc_i;
    word_t     inst_i;
    word_t     result_i;
    word_t     store_data_i;
    reg_addr_t rs_addr_i;
    word_t     rs_data_o;
    logic      retire_o;
    logic      rf_we_o;
    reg_addr_t rd_addr_o;
    word_t     wb_data_o;

    // Stimulus table and expected write-back per row
    word_t     tbl_pc     [MAX_ROWS];
    word_t     tbl_inst   [MAX_ROWS];
    word_t     tbl_result [MAX_ROWS];
    word_t     tbl_store  [MAX_ROWS];
    logic      tbl_we     [MAX_ROWS];
    reg_addr_t tbl_rd     [MAX_ROWS];
    word_t     tbl_data   [MAX_ROWS];
    int        num_rows;
    bit        table_ready;
    int        seed;

    // Expected register contents after all rows retire
    word_t     shadow_regs [NUM_REGS];

    // Row indices still in flight
    int        sb_q [$];

    int        main_pass;
    int        main_fail;
    int        row_pass;
    int        row_fail;
    int        stray_retires;

    rv_backend_top rv_backend_top_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .result_i     (result_i),
        .store_data_i (store_data_i),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o),
        .retire_o     (retire_o),
        .rf_we_o      (rf_we_o),
        .rd_addr_o    (rd_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Only opcode, rd and funct3 matter to the back end
    function automatic word_t make_inst(opcode_e op, logic [2:0] f3, reg_addr_t rd);
        return {7'b0, 5'd3, 5'd2, f3, rd, op};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              inout bit ok);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got,
                                  input reg_addr_t exp, inout bit ok);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp,
                             inout bit ok);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            ok = 1'b0;
        end
    endtask

    task automatic add_row(input word_t pc, input word_t inst, input word_t result,
                           input word_t sdata, input logic we, input reg_addr_t rd,
                           input word_t data);
        tbl_pc[num_rows]     = pc;
        tbl_inst[num_rows]   = inst;
        tbl_result[num_rows] = result;
        tbl_store[num_rows]  = sdata;
        tbl_we[num_rows]     = we;
        tbl_rd[num_rows]     = rd;
        tbl_data[num_rows]   = data;
        if (we && (rd != '0)) begin
            shadow_regs[rd] = data;
        end
        num_rows++;
    endtask

    task automatic build_table;
        word_t rnd_a;
        word_t rnd_b;
        word_t rnd_c;
        word_t rnd_d;
        word_t rnd_store;
        seed      = 32'hc404;
        rnd_a     = $random(seed);
        rnd_b     = $random(seed);
        rnd_c     = $random(seed);
        rnd_d     = $random(seed);
        rnd_store = $random(seed);
        for (int r = 0; r < NUM_REGS; r++) begin
            shadow_regs[r] = '0;
        end
        num_rows = 0;
        // ALU class writes the execute result
        add_row(32'h10, make_inst(OP, 3'b000, 5'd1), rnd_a, 32'h0, 1'b1, 5'd1, rnd_a);
        add_row(32'h14, make_inst(OP_IMM, 3'b000, 5'd2), rnd_b, 32'h0, 1'b1, 5'd2, rnd_b);
        add_row(32'h18, make_inst(LUI, 3'b000, 5'd3), 32'h1234_5000, 32'h0,
                1'b1, 5'd3, 32'h1234_5000);
        add_row(32'h1c, make_inst(AUIPC, 3'b000, 5'd4), rnd_c, 32'h0, 1'b1, 5'd4, rnd_c);
        // Jumps link pc+4
        add_row(32'h100, make_inst(JAL, 3'b000, 5'd5), 32'h180, 32'h0, 1'b1, 5'd5, 32'h104);
        add_row(32'h200, make_inst(JALR, 3'b000, 5'd6), 32'h240, 32'h0, 1'b1, 5'd6, 32'h204);
        // Word 0x40 becomes 8899aabb and is read back at once
        add_row(32'h204, make_inst(STORE, W, 5'd9), 32'h40, 32'h8899_aabb, 1'b0, 5'd0, 32'h0);
        add_row(32'h208, make_inst(LOAD, W, 5'd7), 32'h40, 32'h0, 1'b1, 5'd7, 32'h8899_aabb);
        // Byte lane 1 becomes f0 so the word reads 8899f0bb
        add_row(32'h20c, make_inst(STORE, B, 5'd1), 32'h41, 32'h0000_00f0, 1'b0, 5'd0, 32'h0);
        add_row(32'h210, make_inst(LOAD, B, 5'd8), 32'h41, 32'h0, 1'b1, 5'd8, 32'hffff_fff0);
        add_row(32'h214, make_inst(LOAD, BU, 5'd9), 32'h41, 32'h0, 1'b1, 5'd9, 32'h0000_00f0);
        // Upper half becomes 7e01 so the word reads 7e01f0bb
        add_row(32'h218, make_inst(STORE, H, 5'd2), 32'h42, 32'h0000_7e01, 1'b0, 5'd0, 32'h0);
        add_row(32'h21c, make_inst(LOAD, H, 5'd10), 32'h42, 32'h0, 1'b1, 5'd10, 32'h0000_7e01);
        add_row(32'h220, make_inst(LOAD, HU, 5'd11), 32'h40, 32'h0, 1'b1, 5'd11, 32'h0000_f0bb);
        add_row(32'h224, make_inst(LOAD, H, 5'd12), 32'h40, 32'h0, 1'b1, 5'd12, 32'hffff_f0bb);
        add_row(32'h228, make_inst(LOAD, B, 5'd13), 32'h43, 32'h0, 1'b1, 5'd13, 32'h0000_007e);
        add_row(32'h22c, make_inst(BRANCH, 3'b001, 5'd14), 32'h1, 32'h0, 1'b0, 5'd0, 32'h0);
        // x0 write retires but is dropped
        add_row(32'h230, make_inst(OP, 3'b000, 5'd0), 32'hdead_beef, 32'h0,
                1'b1, 5'd0, 32'hdead_beef);
        add_row(32'h234, make_inst(STORE, W, 5'd4), 32'h80, rnd_store, 1'b0, 5'd0, 32'h0);
        add_row(32'h238, make_inst(LOAD, W, 5'd14), 32'h80, 32'h0, 1'b1, 5'd14, rnd_store);
        // CSR access has no write-back
        add_row(32'h23c, make_inst(SYSTEM, 3'b001, 5'd15), 32'h55, 32'h0, 1'b0, 5'd0, 32'h0);
        add_row(32'h240, make_inst(OP, 3'b000, 5'd1), rnd_d, 32'h0, 1'b1, 5'd1, rnd_d);
        add_row(32'h244, make_inst(LOAD, BU, 5'd16), 32'h43, 32'h0, 1'b1, 5'd16, 32'h0000_007e);
    endtask

    task automatic record_result(input string name, input bit ok);
        if (ok) begin
            main_pass++;
            $display("%s: pass", name);
        end else begin
            main_fail++;
            $display("%s: fail", name);
        end
    endtask

    // Scoreboard pops one expected row per retire
    initial begin
        int idx;
        bit ok;
        row_pass      = 0;
        row_fail      = 0;
        stray_retires = 0;
        forever begin
            @(negedge clk);
            if (retire_o === 1'b1) begin
                if (sb_q.size() == 0) begin
                    $display("Unexpected retire with no instruction in flight at %0t", $time);
                    stray_retires++;
                end else begin
                    idx = sb_q.pop_front();
                    ok  = 1'b1;
                    check_bit("rf_we_o", rf_we_o, tbl_we[idx], ok);
                    if (tbl_we[idx]) begin
                        check_reg_addr("rd_addr_o", rd_addr_o, tbl_rd[idx], ok);
                    end
                    check_word("wb_data_o", wb_data_o, tbl_data[idx], ok);
                    if (ok) begin
                        row_pass++;
                        $display("row %0d retire: pass", idx);
                    end else begin
                        row_fail++;
                        $display("row %0d retire: fail", idx);
                    end
                end
            end
        end
    end

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (RESET_CYCLES + IDLE_CYCLES + num_rows + NUM_REGS + MARGIN_CYCLES)
                   * CLK_PERIOD;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the run did not finish", limit_ns);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        bit ok;
        int drain;
        int missing;
        int total_fail;
        rst          = 1'b1;
        in_valid_i   = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        result_i     = '0;
        store_data_i = '0;
        rs_addr_i    = '0;
        main_pass    = 0;
        main_fail    = 0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;

        // No retire during reset or before the first strobe
        ok = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit("retire_o", retire_o, 1'b0, ok);
            check_bit("rf_we_o", rf_we_o, 1'b0, ok);
        end
        rst = 1'b0;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_bit("retire_o", retire_o, 1'b0, ok);
            check_bit("rf_we_o", rf_we_o, 1'b0, ok);
        end
        record_result("idle after reset", ok);

        // Back-to-back strobes
        for (int i = 0; i < num_rows; i++) begin
            @(negedge clk);
            in_valid_i   = 1'b1;
            pc_i         = tbl_pc[i];
            inst_i       = tbl_inst[i];
            result_i     = tbl_result[i];
            store_data_i = tbl_store[i];
            sb_q.push_back(i);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
        inst_i     = '0;

        drain = 0;
        while ((sb_q.size() > 0) && (drain < DRAIN_LIMIT)) begin
            @(posedge clk);
            drain++;
        end
        missing = sb_q.size();
        if (missing > 0) begin
            $display("%0d instructions were accepted but never retired", missing);
            main_fail++;
        end
        repeat (2) @(negedge clk);

        // Register file contents through the read port
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge clk);
            rs_addr_i = reg_addr_t'(r);
            #(CLK_PERIOD/10);
            ok = 1'b1;
            check_word("rs_data_o", rs_data_o, shadow_regs[r], ok);
            record_result($sformatf("read x%0d", r), ok);
        end

        total_fail = main_fail + row_fail + stray_retires;
        $display("Summary: %0d passed, %0d failed, %0d unexpected retires",
                 main_pass + row_pass, main_fail + row_fail, stray_retires);
        if (total_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_stage/mem_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module mem_stage
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid_i,
    input  word_t pc_i,
    input  word_t inst_i,
    input  word_t result_i,
    input  word_t store_data_i,
    output logic  valid_o,
    output word_t pc_o,
    output word_t inst_o,
    output word_t result_o,
    output word_t load_data_o
);

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);
    localparam int LANES = $bits(byte_en_t);

    word_t            dmem [`RV_DMEM_WORDS];
    opcode_e          opcode;
    mem_size_e        size;
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_off;
    logic             store_en;
    byte_en_t         byte_en;
    word_t            store_word;
    word_t            read_word;
    logic [7:0]       read_byte;
    logic [15:0]      read_half;
    word_t            load_word;

    assign opcode   = opcode_e'(inst_i[OPCODE_W-1:0]);
    assign size     = mem_size_e'(inst_i[12 +: FUNCT3_W]);
    // Result is the byte address, memory is word addressed
    assign word_idx = result_i[2 +: IDX_W];
    assign byte_off = result_i[1:0];
    assign store_en = in_valid_i && (opcode == STORE);

    // Store lanes, data replicated so every enabled lane sees it
    always_comb begin
        byte_en    = '0;
        store_word = store_data_i;
        case (size)
            B: begin
                byte_en    = byte_en_t'(1) << byte_off;
                store_word = {4{store_data_i[7:0]}};
            end
            H: begin
                byte_en    = byte_off[1] ? 4'b1100 : 4'b0011;
                store_word = {2{store_data_i[15:0]}};
            end
            W: begin
                byte_en = '1;
            end
            default: begin
                byte_en = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= `RV_RESET_WORD;
            end
        end else if (store_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (byte_en[b]) begin
                    dmem[word_idx][8*b +: 8] <= store_word[8*b +: 8];
                end
            end
        end
    end

    // Load path, lane select then extend
    assign read_word = dmem[word_idx];
    assign read_byte = read_word[8*byte_off +: 8];
    assign read_half = byte_off[1] ? read_word[31:16] : read_word[15:0];

    always_comb begin
        case (size)
            B:       load_word = {{24{read_byte[7]}}, read_byte};
            BU:      load_word = {24'b0, read_byte};
            H:       load_word = {{16{read_half[15]}}, read_half};
            HU:      load_word = {16'b0, read_half};
            default: load_word = read_word;
        endcase
    end

    // Stage register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o     <= 1'b0;
            pc_o        <= `RV_RESET_WORD;
            inst_o      <= `RV_RESET_WORD;
            result_o    <= `RV_RESET_WORD;
            load_data_o <= `RV_RESET_WORD;
        end else begin
            valid_o <= in_valid_i;
            if (in_valid_i) begin
                pc_o        <= pc_i;
                inst_o      <= inst_i;
                result_o    <= result_i;
                load_data_o <= load_word;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the back-end testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module rv_backend_tb \
    -f verilog.f \
    --Mdir obj_dir \
    -o rv_backend_sim

./obj_dir/rv_backend_sim > sim.log 2>&1

cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr_i,
    output word_t     rdata_o
);

    localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

    word_t regs [NUM_REGS];

    // x0 is never written so it reads zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational read, new value visible after the write edge
    assign rdata_o = regs[raddr_i];

endmodule

// ==== source/rv_backend_top.sv ====
`timescale 1ns/1ps

module rv_backend_top
    import rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  word_t     result_i,
    input  word_t     store_data_i,
    input  reg_addr_t rs_addr_i,
    output word_t     rs_data_o,
    output logic      retire_o,
    output logic      rf_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     wb_data_o
);

    // Memory stage to write-back stage
    logic      mem_valid;
    word_t     mem_pc;
    word_t     mem_inst;
    word_t     mem_result;
    word_t     mem_load_data;

    // Write-back stage to register file
    logic      rf_we;
    reg_addr_t rd_addr;
    word_t     wb_data;

    mem_stage mem_stage_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .result_i     (result_i),
        .store_data_i (store_data_i),
        .valid_o      (mem_valid),
        .pc_o         (mem_pc),
        .inst_o       (mem_inst),
        .result_o     (mem_result),
        .load_data_o  (mem_load_data)
    );

    wb_stage wb_stage_i (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (mem_valid),
        .pc_i        (mem_pc),
        .inst_i      (mem_inst),
        .result_i    (mem_result),
        .load_data_i (mem_load_data),
        .retire_o    (retire_o),
        .rf_we_o     (rf_we),
        .rd_addr_o   (rd_addr),
        .wb_data_o   (wb_data)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst     (rst),
        .we_i    (rf_we),
        .waddr_i (rd_addr),
        .wdata_i (wb_data),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

    assign rf_we_o   = rf_we;
    assign rd_addr_o = rd_addr;
    assign wb_data_o = wb_data;

endmodule

// ==== source/wb_stage.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module wb_stage
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_i,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  word_t     result_i,
    input  word_t     load_data_i,
    output logic      retire_o,
    output logic      rf_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     wb_data_o
);

    logic    valid_q;
    word_t   pc_q;
    word_t   inst_q;
    word_t   result_q;
    word_t   load_q;
    opcode_e opcode;
    wb_src_e wb_src;
    word_t   link_addr;

    // Stage register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= 1'b0;
            pc_q     <= `RV_RESET_WORD;
            inst_q   <= `RV_RESET_WORD;
            result_q <= `RV_RESET_WORD;
            load_q   <= `RV_RESET_WORD;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                pc_q     <= pc_i;
                inst_q   <= inst_i;
                result_q <= result_i;
                load_q   <= load_data_i;
            end
        end
    end

    assign opcode    = opcode_e'(inst_q[OPCODE_W-1:0]);
    assign link_addr = pc_q + `RV_PC_STEP;

    // Write-back source per opcode
    always_comb begin
        case (opcode)
            LUI, AUIPC, OP, OP_IMM: wb_src = ALU;
            LOAD:                   wb_src = MEM;
            JAL, JALR:              wb_src = LINK;
            default:                wb_src = NONE;
        endcase
    end

    always_comb begin
        case (wb_src)
            ALU:     wb_data_o = result_q;
            MEM:     wb_data_o = load_q;
            LINK:    wb_data_o = link_addr;
            default: wb_data_o = '0;
        endcase
    end

    assign retire_o  = valid_q;
    // Stores, branches and CSR ops retire without a write
    assign rf_we_o   = valid_q && (wb_src != NONE);
    assign rd_addr_o = inst_q[11:7];

endmodule

// ==== verilog.f ====
+incdir+common
common/rv_isa_pkg.sv
common/rv_pipe_pkg.sv
mem_stage/mem_stage.sv
source/wb_stage.sv
source/reg_file.sv
source/rv_backend_top.sv
dv/rv_backend_tb.sv
